// ==== hw/decode_pkg.sv ====
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [14:0] op_vec_t;

    // bit positions in the one-hot op vector.
    localparam int OP_ADDU  = 0;
    localparam int OP_SUBU  = 1;
    localparam int OP_AND   = 2;
    localparam int OP_OR    = 3;
    localparam int OP_SLL   = 4;
    localparam int OP_JR    = 5;
    localparam int OP_ADDIU = 6;
    localparam int OP_ORI   = 7;
    localparam int OP_LUI   = 8;
    localparam int OP_LW    = 9;
    localparam int OP_SW    = 10;
    localparam int OP_BEQ   = 11;
    localparam int OP_BNE   = 12;
    localparam int OP_J     = 13;
    localparam int OP_RSVD  = 14;

    // primary opcode field, inst[31:26].
    localparam opcode_t OPC_SPECIAL = 6'h00;
    localparam opcode_t OPC_J       = 6'h02;
    localparam opcode_t OPC_BEQ     = 6'h04;
    localparam opcode_t OPC_BNE     = 6'h05;
    localparam opcode_t OPC_ADDIU   = 6'h09;
    localparam opcode_t OPC_ORI     = 6'h0d;
    localparam opcode_t OPC_LUI     = 6'h0f;
    localparam opcode_t OPC_LW      = 6'h23;
    localparam opcode_t OPC_SW      = 6'h2b;

    // funct field of SPECIAL, inst[5:0].
    localparam opcode_t FUNCT_SLL  = 6'h00;
    localparam opcode_t FUNCT_JR   = 6'h08;
    localparam opcode_t FUNCT_ADDU = 6'h21;
    localparam opcode_t FUNCT_SUBU = 6'h23;
    localparam opcode_t FUNCT_AND  = 6'h24;
    localparam opcode_t FUNCT_OR   = 6'h25;

    // an all-zero value of this bus is a bubble.
    typedef struct packed {
        logic        valid;
        op_vec_t     op;
        word_t       pc;
        word_t       inst;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  sa;
        logic        w_reg_ena;
        reg_addr_t   w_reg_dst;
        logic [15:0] imme;
        logic [25:0] j_imme;
        logic        is_branch;
        logic        is_j_imme;
        logic        is_jr;
        logic        is_ls;
        logic        in_delay_slot;
        logic        is_inst_adel;
    } id1_bus_t;

    typedef struct packed {
        logic      ena;
        reg_addr_t dst;
        word_t     data;
    } wb_bus_t;

    typedef struct packed {
        id1_bus_t dec;
        word_t    rs_value;
        word_t    rt_value;
        word_t    ext_imme;
        word_t    branch_target;
        word_t    jump_target;
    } id2_bus_t;

endpackage

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  logic                 valid_i,
    input  decode_pkg::word_t    inst_i,
    input  decode_pkg::word_t    pc_i,
    input  decode_pkg::id1_bus_t prev_i,
    output decode_pkg::id1_bus_t id1_o
);

    decode_pkg::opcode_t   opcode;
    decode_pkg::opcode_t   funct;
    decode_pkg::op_vec_t   op;
    decode_pkg::reg_addr_t dst;
    logic                  is_rtype;
    logic                  writes_reg;

    assign opcode   = inst_i[31:26];
    assign funct    = inst_i[5:0];
    assign is_rtype = (opcode == decode_pkg::OPC_SPECIAL);

    // anything outside the subset, including unknown SPECIAL functs, is reserved.
    always_comb begin
        op = '0;
        case (opcode)
            decode_pkg::OPC_SPECIAL: begin
                case (funct)
                    decode_pkg::FUNCT_ADDU: op[decode_pkg::OP_ADDU] = 1'b1;
                    decode_pkg::FUNCT_SUBU: op[decode_pkg::OP_SUBU] = 1'b1;
                    decode_pkg::FUNCT_AND:  op[decode_pkg::OP_AND]  = 1'b1;
                    decode_pkg::FUNCT_OR:   op[decode_pkg::OP_OR]   = 1'b1;
                    decode_pkg::FUNCT_SLL:  op[decode_pkg::OP_SLL]  = 1'b1;
                    decode_pkg::FUNCT_JR:   op[decode_pkg::OP_JR]   = 1'b1;
                    default:                op[decode_pkg::OP_RSVD] = 1'b1;
                endcase
            end
            decode_pkg::OPC_ADDIU: op[decode_pkg::OP_ADDIU] = 1'b1;
            decode_pkg::OPC_ORI:   op[decode_pkg::OP_ORI]   = 1'b1;
            decode_pkg::OPC_LUI:   op[decode_pkg::OP_LUI]   = 1'b1;
            decode_pkg::OPC_LW:    op[decode_pkg::OP_LW]    = 1'b1;
            decode_pkg::OPC_SW:    op[decode_pkg::OP_SW]    = 1'b1;
            decode_pkg::OPC_BEQ:   op[decode_pkg::OP_BEQ]   = 1'b1;
            decode_pkg::OPC_BNE:   op[decode_pkg::OP_BNE]   = 1'b1;
            decode_pkg::OPC_J:     op[decode_pkg::OP_J]     = 1'b1;
            default:               op[decode_pkg::OP_RSVD]  = 1'b1;
        endcase
    end

    // R-type writes rd, I-type writes rt.
    assign dst = is_rtype ? inst_i[15:11] : inst_i[20:16];

    assign writes_reg = op[decode_pkg::OP_ADDU]  | op[decode_pkg::OP_SUBU] |
                        op[decode_pkg::OP_AND]   | op[decode_pkg::OP_OR]   |
                        op[decode_pkg::OP_SLL]   | op[decode_pkg::OP_ADDIU] |
                        op[decode_pkg::OP_ORI]   | op[decode_pkg::OP_LUI]  |
                        op[decode_pkg::OP_LW];

    always_comb begin
        id1_o           = '0;
        id1_o.valid     = valid_i;
        id1_o.op        = op;
        id1_o.pc        = pc_i;
        id1_o.inst      = inst_i;
        id1_o.rs        = inst_i[25:21];
        id1_o.rt        = inst_i[20:16];
        id1_o.rd        = inst_i[15:11];
        id1_o.sa        = inst_i[10:6];
        id1_o.w_reg_ena = writes_reg && (dst != '0);
        id1_o.w_reg_dst = dst;
        id1_o.imme      = inst_i[15:0];
        id1_o.j_imme    = inst_i[25:0];
        id1_o.is_branch = op[decode_pkg::OP_BEQ] | op[decode_pkg::OP_BNE];
        id1_o.is_j_imme = op[decode_pkg::OP_J];
        id1_o.is_jr     = op[decode_pkg::OP_JR];
        id1_o.is_ls     = op[decode_pkg::OP_LW] | op[decode_pkg::OP_SW];
        // the held instruction is the direct predecessor, unless a bubble sits there.
        id1_o.in_delay_slot = prev_i.valid &
                              (prev_i.is_branch | prev_i.is_j_imme | prev_i.is_jr);
        id1_o.is_inst_adel  = (pc_i[1:0] != 2'b00);
    end

endmodule

// ==== hw/issue_id2.sv ====
`timescale 1ns/1ps

module issue_id2 (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    input  decode_pkg::id1_bus_t id1_i,
    output decode_pkg::id1_bus_t id1_o
);

    logic clear;
    logic load;

    // a stall wins over a flush, so the held instruction survives both.
    assign clear = !stall_i && (flush_i || !id1_i.valid);
    assign load  = !stall_i && !flush_i && id1_i.valid;

    always_ff @(posedge clk) begin
        if (rst_i || clear) begin
            id1_o <= '0;
        end else if (load) begin
            id1_o <= id1_i;
        end
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  rst_i,
    input  decode_pkg::reg_addr_t raddr_a_i,
    input  decode_pkg::reg_addr_t raddr_b_i,
    output decode_pkg::word_t     rdata_a_o,
    output decode_pkg::word_t     rdata_b_o,
    input  decode_pkg::wb_bus_t   wb_i
);

    decode_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.ena && (wb_i.dst != '0)) begin
            regs[wb_i.dst] <= wb_i.data;
        end
    end

    // same-cycle writes are forwarded, so a read never sees stale data.
    function automatic decode_pkg::word_t read_port(decode_pkg::reg_addr_t addr);
        decode_pkg::word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wb_i.ena && (wb_i.dst == addr)) begin
            value = wb_i.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    // the read ports also follow the array and the write port, not only the addresses.
    always_comb begin
        rdata_a_o = read_port(raddr_a_i);
        rdata_b_o = read_port(raddr_b_i);
    end

endmodule

// ==== hw/operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage (
    input  decode_pkg::id1_bus_t  id1_i,
    output decode_pkg::reg_addr_t raddr_a_o,
    output decode_pkg::reg_addr_t raddr_b_o,
    input  decode_pkg::word_t     rdata_a_i,
    input  decode_pkg::word_t     rdata_b_i,
    output decode_pkg::id2_bus_t  id2_o
);

    decode_pkg::word_t sext_imme;
    decode_pkg::word_t zext_imme;
    decode_pkg::word_t lui_imme;
    decode_pkg::word_t ext_imme;
    decode_pkg::word_t pc_plus4;
    decode_pkg::word_t branch_offset;

    assign raddr_a_o = id1_i.rs;
    assign raddr_b_o = id1_i.rt;

    assign sext_imme = {{16{id1_i.imme[15]}}, id1_i.imme};
    assign zext_imme = {16'h0000, id1_i.imme};
    assign lui_imme  = {id1_i.imme, 16'h0000};

    // logical immediates are zero-extended, the rest sign-extended.
    always_comb begin
        if (id1_i.op[decode_pkg::OP_ORI]) begin
            ext_imme = zext_imme;
        end else if (id1_i.op[decode_pkg::OP_LUI]) begin
            ext_imme = lui_imme;
        end else begin
            ext_imme = sext_imme;
        end
    end

    assign pc_plus4      = id1_i.pc + 32'd4;
    assign branch_offset = {sext_imme[29:0], 2'b00};

    always_comb begin
        id2_o               = '0;
        id2_o.dec           = id1_i;
        id2_o.rs_value      = rdata_a_i;
        id2_o.rt_value      = rdata_b_i;
        id2_o.ext_imme      = ext_imme;
        id2_o.branch_target = pc_plus4 + branch_offset;
        // J stays within the 256 MB region of the delay slot.
        id2_o.jump_target   = {pc_plus4[31:28], id1_i.j_imme, 2'b00};
    end

endmodule

// ==== hw/decode_top.sv ====
`timescale 1ns/1ps

module decode_top (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    input  logic                 valid_i,
    input  decode_pkg::word_t    inst_i,
    input  decode_pkg::word_t    pc_i,
    input  decode_pkg::wb_bus_t  wb_i,
    output decode_pkg::id2_bus_t id2_o
);

    decode_pkg::id1_bus_t  id1_d;
    decode_pkg::id1_bus_t  id1_q;
    decode_pkg::reg_addr_t raddr_a;
    decode_pkg::reg_addr_t raddr_b;
    decode_pkg::word_t     rdata_a;
    decode_pkg::word_t     rdata_b;

    inst_decoder u_inst_decoder (
        .valid_i (valid_i),
        .inst_i  (inst_i),
        .pc_i    (pc_i),
        .prev_i  (id1_q),
        .id1_o   (id1_d)
    );

    issue_id2 u_issue_id2 (
        .clk     (clk),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .id1_i   (id1_d),
        .id1_o   (id1_q)
    );

    operand_stage u_operand_stage (
        .id1_i     (id1_q),
        .raddr_a_o (raddr_a),
        .raddr_b_o (raddr_b),
        .rdata_a_i (rdata_a),
        .rdata_b_i (rdata_b),
        .id2_o     (id2_o)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_i     (rst_i),
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .wb_i      (wb_i)
    );

endmodule

// ==== testbench/tb_decode_top.sv ====
`timescale 1ns/1ps

module tb_decode_top;

    localparam int NUM_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;

    logic                 clk;
    logic                 rst_i;
    logic                 stall_i;
    logic                 flush_i;
    logic                 valid_i;
    decode_pkg::word_t    inst_i;
    decode_pkg::word_t    pc_i;
    decode_pkg::wb_bus_t  wb_i;
    decode_pkg::id2_bus_t id2_o;

    logic [15:0]          lfsr;
    int                   errors;
    int                   cycle;
    int                   timeout_count;
    decode_pkg::id1_bus_t held;
    decode_pkg::id1_bus_t pending;
    decode_pkg::word_t    model_regs [32];

    decode_top u_dut (
        .clk     (clk),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .valid_i (valid_i),
        .inst_i  (inst_i),
        .pc_i    (pc_i),
        .wb_i    (wb_i),
        .id2_o   (id2_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // 16-bit Fibonacci LFSR, taps 16, 14, 13 and 11, one step per bit taken.
    function automatic decode_pkg::word_t rand_bits(input int n);
        decode_pkg::word_t v;
        logic              fb;
        int                i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // selectors 0 to 13 follow the subset order, 14 and 15 are two kinds of reserved word.
    function automatic decode_pkg::word_t encode(input logic [3:0] sel, input logic [25:0] f);
        case (sel)
            4'd0:    return {decode_pkg::OPC_SPECIAL, f[25:6], decode_pkg::FUNCT_ADDU};
            4'd1:    return {decode_pkg::OPC_SPECIAL, f[25:6], decode_pkg::FUNCT_SUBU};
            4'd2:    return {decode_pkg::OPC_SPECIAL, f[25:6], decode_pkg::FUNCT_AND};
            4'd3:    return {decode_pkg::OPC_SPECIAL, f[25:6], decode_pkg::FUNCT_OR};
            4'd4:    return {decode_pkg::OPC_SPECIAL, f[25:6], decode_pkg::FUNCT_SLL};
            4'd5:    return {decode_pkg::OPC_SPECIAL, f[25:6], decode_pkg::FUNCT_JR};
            4'd6:    return {decode_pkg::OPC_ADDIU, f};
            4'd7:    return {decode_pkg::OPC_ORI, f};
            4'd8:    return {decode_pkg::OPC_LUI, f};
            4'd9:    return {decode_pkg::OPC_LW, f};
            4'd10:   return {decode_pkg::OPC_SW, f};
            4'd11:   return {decode_pkg::OPC_BEQ, f};
            4'd12:   return {decode_pkg::OPC_BNE, f};
            4'd13:   return {decode_pkg::OPC_J, f};
            4'd14:   return {6'h3f, f};
            default: return {decode_pkg::OPC_SPECIAL, f[25:6], 6'h2a};
        endcase
    endfunction

    // expected stage-one bus; the delay-slot flag is filled in when the word is accepted.
    function automatic decode_pkg::id1_bus_t expect_fields(input logic [3:0] sel,
                                                           input decode_pkg::word_t inst,
                                                           input decode_pkg::word_t pc);
        decode_pkg::id1_bus_t  e;
        decode_pkg::reg_addr_t dst;
        logic                  rtype;
        logic                  writes;
        int                    idx;
        e      = '0;
        rtype  = (sel <= 4'd5) || (sel == 4'd15);
        writes = (sel <= 4'd4) || ((sel >= 4'd6) && (sel <= 4'd9));
        dst    = rtype ? inst[15:11] : inst[20:16];
        if (sel >= 4'd14) begin
            idx = decode_pkg::OP_RSVD;
        end else begin
            idx = int'(sel);
        end
        e.valid        = 1'b1;
        e.op           = 15'd1 << idx;
        e.pc           = pc;
        e.inst         = inst;
        e.rs           = inst[25:21];
        e.rt           = inst[20:16];
        e.rd           = inst[15:11];
        e.sa           = inst[10:6];
        e.w_reg_ena    = writes && (dst != 5'd0);
        e.w_reg_dst    = dst;
        e.imme         = inst[15:0];
        e.j_imme       = inst[25:0];
        e.is_branch    = (sel == 4'd11) || (sel == 4'd12);
        e.is_j_imme    = (sel == 4'd13);
        e.is_jr        = (sel == 4'd5);
        e.is_ls        = (sel == 4'd9) || (sel == 4'd10);
        e.is_inst_adel = (pc[1:0] != 2'b00);
        return e;
    endfunction

    function automatic decode_pkg::word_t expect_read(input decode_pkg::reg_addr_t addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (wb_i.ena && (wb_i.dst == addr)) begin
            return wb_i.data;
        end
        return model_regs[addr];
    endfunction

    // applies the inputs that the DUT sampled at this edge.
    task automatic update_model();
        decode_pkg::id1_bus_t accepted;
        int                   i;
        if (rst_i) begin
            held = '0;
            for (i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
        end else begin
            if (wb_i.ena && (wb_i.dst != 5'd0)) begin
                model_regs[wb_i.dst] = wb_i.data;
            end
            if (!stall_i) begin
                if (flush_i || !valid_i) begin
                    held = '0;
                end else begin
                    accepted = pending;
                    accepted.in_delay_slot = held.valid &
                                             (held.is_branch | held.is_j_imme | held.is_jr);
                    held = accepted;
                end
            end
        end
    endtask

    task automatic drive_inputs(input int cyc);
        decode_pkg::word_t   r;
        decode_pkg::word_t   inst;
        decode_pkg::word_t   pc;
        decode_pkg::wb_bus_t wb;
        logic [3:0]          sel;
        logic [25:0]         fields;
        r      = rand_bits(4);
        sel    = r[3:0];
        r      = rand_bits(26);
        fields = r[25:0];
        pc     = rand_bits(32);
        r      = rand_bits(4);
        if (r[3:0] != 4'd0) begin
            pc[1:0] = 2'b00;
        end else if (pc[1:0] == 2'b00) begin
            pc[1:0] = 2'b10;
        end
        inst    = encode(sel, fields);
        pending = expect_fields(sel, inst, pc);
        r       = rand_bits(5);
        wb.dst  = r[4:0];
        wb.data = rand_bits(32);
        wb.ena  = cyc[0];
        valid_i <= (rand_bits(3) != 32'd0);
        stall_i <= (rand_bits(2) == 32'd0);
        flush_i <= (rand_bits(3) == 32'd0);
        inst_i  <= inst;
        pc_i    <= pc;
        wb_i    <= wb;
    endtask

    task automatic report_word(input string what, input decode_pkg::word_t got,
                               input decode_pkg::word_t exp);
        errors++;
        $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic check_outputs();
        decode_pkg::word_t sext;
        decode_pkg::word_t pc4;
        decode_pkg::word_t exp_ext;
        sext = {{16{held.imme[15]}}, held.imme};
        pc4  = held.pc + 32'd4;
        if (held.op[decode_pkg::OP_ORI]) begin
            exp_ext = {16'h0000, held.imme};
        end else if (held.op[decode_pkg::OP_LUI]) begin
            exp_ext = {held.imme, 16'h0000};
        end else begin
            exp_ext = sext;
        end
        if (id2_o.dec !== held) begin
            errors++;
            $display("mismatch at %0t: decoded bus got %h expected %h", $time, id2_o.dec, held);
        end
        if (id2_o.rs_value !== expect_read(held.rs)) begin
            report_word("rs_value", id2_o.rs_value, expect_read(held.rs));
        end
        if (id2_o.rt_value !== expect_read(held.rt)) begin
            report_word("rt_value", id2_o.rt_value, expect_read(held.rt));
        end
        if (id2_o.ext_imme !== exp_ext) begin
            report_word("ext_imme", id2_o.ext_imme, exp_ext);
        end
        if (id2_o.branch_target !== pc4 + (sext << 2)) begin
            report_word("branch_target", id2_o.branch_target, pc4 + (sext << 2));
        end
        if (id2_o.jump_target !== {pc4[31:28], held.j_imme, 2'b00}) begin
            report_word("jump_target", id2_o.jump_target, {pc4[31:28], held.j_imme, 2'b00});
        end
    endtask

    initial begin
        rst_i   = 1'b1;
        stall_i = 1'b0;
        flush_i = 1'b0;
        valid_i = 1'b0;
        inst_i  = '0;
        pc_i    = '0;
        wb_i    = '0;
        lfsr    = 16'd34376;
        errors  = 0;
        held    = '0;
        pending = '0;
        for (cycle = 1; cycle <= NUM_CYCLES; cycle++) begin
            @(posedge clk);
            update_model();
            // reset is seen by the DUT at the first two edges.
            if (cycle == 2) begin
                rst_i <= 1'b0;
            end
            if (cycle >= 2) begin
                drive_inputs(cycle);
            end
            @(negedge clk);
            check_outputs();
        end
        $display("%0d errors in %0d cycles", errors, NUM_CYCLES);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        timeout_count = 0;
        while (timeout_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            timeout_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
hw/decode_pkg.sv
hw/inst_decoder.sv
hw/issue_id2.sv
hw/reg_file.sv
hw/operand_stage.sv
hw/decode_top.sv
testbench/tb_decode_top.sv

// ==== Makefile ====
TOP = tb_decode_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f compile.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
